/* design/ahb_block_ram.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module ahb_block_ram import ahb_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sel,
    input  ahb_req_t                ahb_req,
    input  logic [`E902_DATA_W-1:0] hwdata,
    input  logic                    hready_in,
    output ahb_rsp_t                rsp
);

    localparam int AW = `E902_RAM_AW;

    logic [`E902_DATA_W-1:0] mem [2**AW];

    logic                    trans_valid;
    logic                    dp_write;
    logic [AW-1:0]           dp_word;
    logic [1:0]              dp_byte;
    hsize_t                  dp_size;
    logic [3:0]              strb;
    logic [`E902_DATA_W-1:0] rdata_q;

    assign trans_valid = sel && hready_in &&
                         (ahb_req.htrans == htrans_nonseq || ahb_req.htrans == htrans_seq);

    // --------------------------------------------------------------------------
    // data phase capture
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dp_write <= 1'b0;
        end else if (hready_in) begin
            dp_write <= trans_valid && ahb_req.hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (trans_valid) begin
            dp_word <= ahb_req.haddr[AW+1:2];
            dp_byte <= ahb_req.haddr[1:0];
            dp_size <= ahb_req.hsize;
        end
    end

    // byte lanes from size and low address bits
    always_comb begin
        case (dp_size)
            hsize_byte: strb = 4'b0001 << dp_byte;
            hsize_half: strb = dp_byte[1] ? 4'b1100 : 4'b0011;
            default:    strb = 4'b1111;
        endcase
    end

    // --------------------------------------------------------------------------
    // array, write at end of data phase, read with the address phase address
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (dp_write && hready_in) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    mem[dp_word][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
        if (trans_valid && !ahb_req.hwrite) begin
            rdata_q <= mem[ahb_req.haddr[AW+1:2]];
        end
    end

    assign rsp = '{hrdata: rdata_q, hready: 1'b1, hresp: hresp_okay};

endmodule

/* design/ahb_pkg.sv */
package ahb_pkg;

`include "e902_soc_defs.svh"

    // --------------------------------------------------------------------------
    // AHB-Lite transfer encodings
    // --------------------------------------------------------------------------
    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_busy   = 2'b01,
        htrans_nonseq = 2'b10,
        htrans_seq    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        hsize_byte = 3'b000,
        hsize_half = 3'b001,
        hsize_word = 3'b010
    } hsize_t;

    // hresp is a single bit here, only OKAY is ever returned
    localparam logic hresp_okay = 1'b0;

    // --------------------------------------------------------------------------
    // address phase and response
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic [`E902_ADDR_W-1:0] haddr;
        htrans_t                 htrans;
        hsize_t                  hsize;
        logic                    hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic [`E902_DATA_W-1:0] hrdata;
        logic                    hready;
        logic                    hresp;
    } ahb_rsp_t;

endpackage

/* design/ahb_slave_mux.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module ahb_slave_mux import ahb_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  ahb_req_t ahb_req,
    input  ahb_rsp_t ram_rsp,
    input  ahb_rsp_t bridge_rsp,
    output logic     ram_sel,
    output logic     bridge_sel,
    output ahb_rsp_t ahb_rsp
);

    typedef enum logic [1:0] {
        own_none,
        own_ram,
        own_bridge
    } owner_t;

    owner_t owner;

    // address phase decode on the top two bits
    assign ram_sel    = (ahb_req.haddr[31:30] == `E902_REGION_RAM);
    assign bridge_sel = (ahb_req.haddr[31:30] == `E902_REGION_APB);

    // owner of the data phase, moves on only when the bus is ready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= own_none;
        end else if (ahb_rsp.hready) begin
            if (ram_sel) begin
                owner <= own_ram;
            end else if (bridge_sel) begin
                owner <= own_bridge;
            end else begin
                owner <= own_none;
            end
        end
    end

    always_comb begin
        case (owner)
            own_ram:    ahb_rsp = ram_rsp;
            own_bridge: ahb_rsp = bridge_rsp;
            // unmapped, zero data with no wait state
            default:    ahb_rsp = '{hrdata: '0, hready: 1'b1, hresp: hresp_okay};
        endcase
    end

endmodule

/* design/ahb_to_apb.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module ahb_to_apb import ahb_pkg::*, apb_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sel,
    input  ahb_req_t                ahb_req,
    input  logic [`E902_DATA_W-1:0] hwdata,
    input  logic                    hready_in,
    input  logic [`E902_DATA_W-1:0] key_rdata,
    input  logic [`E902_DATA_W-1:0] tube_rdata,
    output ahb_rsp_t                rsp,
    output apb_req_t                key_apb,
    output apb_req_t                tube_apb
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access,
        st_rdreg
    } state_t;

    state_t                  state;
    logic                    accept;
    logic [`E902_APB_AW-1:0] addr_q;
    logic                    write_q;
    logic [3:0]              slot;
    logic [`E902_DATA_W-1:0] rdata_q;
    apb_req_t                apb_base;

    assign accept = sel && hready_in &&
                    (ahb_req.htrans == htrans_nonseq || ahb_req.htrans == htrans_seq);
    assign slot   = addr_q[15:12];

    // --------------------------------------------------------------------------
    // transfer FSM
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   state <= accept ? st_setup : st_idle;
                st_setup:  state <= st_access;
                // reads spend one more cycle in the data register
                st_access: state <= write_q ? st_idle : st_rdreg;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && accept) begin
            addr_q  <= ahb_req.haddr[`E902_APB_AW-1:0];
            write_q <= ahb_req.hwrite;
        end
        if (state == st_access && !write_q) begin
            if (slot == `E902_APB_SLOT_KEY) begin
                rdata_q <= key_rdata;
            end else if (slot == `E902_APB_SLOT_TUBE) begin
                rdata_q <= tube_rdata;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // --------------------------------------------------------------------------
    // APB side, write data straight from the held hwdata
    // --------------------------------------------------------------------------
    always_comb begin
        apb_base         = '0;
        apb_base.paddr   = addr_q;
        apb_base.psel    = (state == st_setup) || (state == st_access);
        apb_base.penable = (state == st_access);
        apb_base.pwrite  = write_q;
        apb_base.pwdata  = hwdata;

        key_apb       = apb_base;
        key_apb.psel  = apb_base.psel && (slot == `E902_APB_SLOT_KEY);
        tube_apb      = apb_base;
        tube_apb.psel = apb_base.psel && (slot == `E902_APB_SLOT_TUBE);
    end

    assign rsp = '{hrdata: rdata_q, hready: (state == st_idle), hresp: hresp_okay};

endmodule

/* design/apb_keyboard.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module apb_keyboard import apb_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  apb_req_t                apb,
    input  logic [3:0]              col_in,
    output logic [`E902_DATA_W-1:0] rdata,
    output logic [3:0]              row,
    output logic                    key_int
);

    localparam int DIV = `E902_KEY_SCAN_DIV;
    localparam int CW  = $clog2(DIV);

    logic [CW-1:0] scan_cnt;
    logic [1:0]    row_idx;
    logic [1:0]    row_q;
    logic [3:0]    col_q;
    logic [1:0]    col_idx;
    logic          held;
    logic          valid;
    key_code_t     code;
    logic          rd_access;

    // --------------------------------------------------------------------------
    // row scan and column sampling
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            row_idx  <= '0;
            row_q    <= '0;
            col_q    <= 4'hf;
        end else begin
            scan_cnt <= (scan_cnt == CW'(DIV - 1)) ? '0 : scan_cnt + 1'b1;
            if (scan_cnt == CW'(DIV - 1)) begin
                row_idx <= row_idx + 1'b1;
            end
            // column paired with the row it was read under
            row_q <= row_idx;
            col_q <= col_in;
        end
    end

    assign row = ~(4'b0001 << row_idx);

    // lowest low column wins
    always_comb begin
        col_idx = '0;
        for (int i = 3; i >= 0; i--) begin
            if (!col_q[i]) begin
                col_idx = 2'(i);
            end
        end
    end

    // --------------------------------------------------------------------------
    // key capture, release and status
    // --------------------------------------------------------------------------
    assign rd_access = apb.psel && apb.penable && !apb.pwrite;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held  <= 1'b0;
            valid <= 1'b0;
            code  <= '0;
        end else begin
            if (!held && col_q != 4'hf) begin
                code  <= {row_q, col_idx};
                valid <= 1'b1;
                held  <= 1'b1;
            end else begin
                if (held && row_q == code[3:2] && col_q[code[1:0]]) begin
                    held <= 1'b0;
                end
                if (rd_access) begin
                    valid <= 1'b0;
                end
            end
        end
    end

    assign rdata   = {{(`E902_DATA_W - 5){1'b0}}, valid, code};
    assign key_int = valid;

endmodule

/* design/apb_pkg.sv */
package apb_pkg;

`include "e902_soc_defs.svh"

    // one request per slave, psel already decoded by the bridge
    typedef struct packed {
        logic [`E902_APB_AW-1:0] paddr;
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`E902_DATA_W-1:0] pwdata;
    } apb_req_t;

    // seven-segment lines, active high, dp in the low bit
    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic dp;
    } seg_t;

    // key number, row * 4 + column
    typedef logic [3:0] key_code_t;

endpackage

/* design/apb_tube.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module apb_tube import apb_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  apb_req_t                apb,
    output logic [`E902_DATA_W-1:0] rdata,
    output logic [5:0]              dig,
    output seg_t                    seg
);

    localparam int NDIG = `E902_TUBE_DIGITS;
    localparam int DIV  = `E902_TUBE_SCAN_DIV;
    localparam int IW   = $clog2(NDIG);
    localparam int CW   = $clog2(DIV);

    logic [4*NDIG-1:0] digits;
    logic [NDIG-1:0]   dots;
    logic [CW-1:0]     scan_cnt;
    logic [IW-1:0]     dig_idx;
    logic [3:0]        digit_val;

    function automatic logic [6:0] hex_to_seg(input logic [3:0] v);
        // segments a to g, a in the top bit
        case (v)
            4'h0: return 7'b1111110;
            4'h1: return 7'b0110000;
            4'h2: return 7'b1101101;
            4'h3: return 7'b1111001;
            4'h4: return 7'b0110011;
            4'h5: return 7'b1011011;
            4'h6: return 7'b1011111;
            4'h7: return 7'b1110000;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1111011;
            4'ha: return 7'b1110111;
            4'hb: return 7'b0011111;
            4'hc: return 7'b1001110;
            4'hd: return 7'b0111101;
            4'he: return 7'b1001111;
            default: return 7'b1000111;
        endcase
    endfunction

    // --------------------------------------------------------------------------
    // registers, digits at offset 0 and dots at offset 4
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digits <= `E902_TUBE_DIGIT_RST;
            dots   <= `E902_TUBE_DOT_RST;
        end else if (apb.psel && apb.penable && apb.pwrite) begin
            if (apb.paddr[2]) begin
                dots <= apb.pwdata[NDIG-1:0];
            end else begin
                digits <= apb.pwdata[4*NDIG-1:0];
            end
        end
    end

    assign rdata = apb.paddr[2] ? {{(`E902_DATA_W - NDIG){1'b0}}, dots}
                                : {{(`E902_DATA_W - 4*NDIG){1'b0}}, digits};

    // --------------------------------------------------------------------------
    // digit scan
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            dig_idx  <= '0;
        end else begin
            scan_cnt <= (scan_cnt == CW'(DIV - 1)) ? '0 : scan_cnt + 1'b1;
            if (scan_cnt == CW'(DIV - 1)) begin
                dig_idx <= (dig_idx == IW'(NDIG - 1)) ? '0 : dig_idx + 1'b1;
            end
        end
    end

    assign dig       = ~(NDIG'(1) << dig_idx);
    assign digit_val = digits[4*dig_idx +: 4];
    assign seg       = {hex_to_seg(digit_val), dots[dig_idx]};

endmodule

/* design/e902_soc.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module e902_soc import ahb_pkg::*, apb_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ahb_req_t                ahb_req,
    input  logic [`E902_DATA_W-1:0] ahb_hwdata,
    output ahb_rsp_t                ahb_rsp,
    input  logic [3:0]              col_in,
    output logic [3:0]              row,
    output logic [5:0]              dig,
    output seg_t                    seg,
    output logic                    key_int
);

    logic                    ram_sel;
    logic                    bridge_sel;
    ahb_rsp_t                ram_rsp;
    ahb_rsp_t                bridge_rsp;
    apb_req_t                key_apb;
    apb_req_t                tube_apb;
    logic [`E902_DATA_W-1:0] key_rdata;
    logic [`E902_DATA_W-1:0] tube_rdata;

    // --------------------------------------------------------------------------
    // system bus
    // --------------------------------------------------------------------------
    ahb_slave_mux i_ahb_slave_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .ahb_req    (ahb_req),
        .ram_rsp    (ram_rsp),
        .bridge_rsp (bridge_rsp),
        .ram_sel    (ram_sel),
        .bridge_sel (bridge_sel),
        .ahb_rsp    (ahb_rsp)
    );

    ahb_block_ram i_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (ram_sel),
        .ahb_req   (ahb_req),
        .hwdata    (ahb_hwdata),
        .hready_in (ahb_rsp.hready),
        .rsp       (ram_rsp)
    );

    ahb_to_apb i_ahb_to_apb (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (bridge_sel),
        .ahb_req    (ahb_req),
        .hwdata     (ahb_hwdata),
        .hready_in  (ahb_rsp.hready),
        .key_rdata  (key_rdata),
        .tube_rdata (tube_rdata),
        .rsp        (bridge_rsp),
        .key_apb    (key_apb),
        .tube_apb   (tube_apb)
    );

    // --------------------------------------------------------------------------
    // peripherals
    // --------------------------------------------------------------------------
    apb_keyboard i_apb_keyboard (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb     (key_apb),
        .col_in  (col_in),
        .rdata   (key_rdata),
        .row     (row),
        .key_int (key_int)
    );

    apb_tube i_apb_tube (
        .clk   (clk),
        .rst_n (rst_n),
        .apb   (tube_apb),
        .rdata (tube_rdata),
        .dig   (dig),
        .seg   (seg)
    );

endmodule

/* e902_soc.f */
+incdir+include
design/ahb_pkg.sv
design/apb_pkg.sv
design/ahb_slave_mux.sv
design/ahb_block_ram.sv
design/ahb_to_apb.sv
design/apb_keyboard.sv
design/apb_tube.sv
design/e902_soc.sv
tb/e902_soc_checker.sv
tb/e902_soc_tb.sv

/* include/e902_soc_defs.svh */
`ifndef E902_SOC_DEFS_SVH
`define E902_SOC_DEFS_SVH

// system bus widths
`define E902_ADDR_W         32
`define E902_DATA_W         32

// data RAM word address, 16K words
`define E902_RAM_AW         14

// APB side address width
`define E902_APB_AW         16

// address map, top two address bits
`define E902_REGION_RAM     2'b01
`define E902_REGION_APB     2'b10

// APB slots, address bits 15:12
`define E902_APB_SLOT_KEY   4'h1
`define E902_APB_SLOT_TUBE  4'h2

// display and keyboard scan
`define E902_TUBE_DIGITS    6
`define E902_TUBE_SCAN_DIV  16
`define E902_KEY_SCAN_DIV   8

// display register reset values
`define E902_TUBE_DIGIT_RST 24'h00_0000
`define E902_TUBE_DOT_RST   6'h00

`endif

/* tb/e902_soc_checker.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module e902_soc_checker import ahb_pkg::*, apb_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input ahb_req_t   ahb_req,
    input ahb_rsp_t   ahb_rsp,
    input apb_req_t   tube_apb,
    input logic [3:0] row,
    input logic [5:0] dig,
    input seg_t       seg,
    input logic       key_int
);

    // segments a to g, a in the top bit
    localparam logic [6:0] HEX_SEG [16] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f,
        7'h70, 7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};

    int          fail_count = 0;
    logic [23:0] digit_model;
    logic [5:0]  dot_model;
    logic [7:0]  seg_expect;
    int          idx;
    logic        accept;
    logic [1:0]  region;

    assign accept = (ahb_req.htrans == htrans_nonseq) && ahb_rsp.hready;
    assign region = ahb_req.haddr[31:30];

    // display registers as seen on the tube APB port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_model <= '0;
            dot_model   <= '0;
        end else if (tube_apb.psel && tube_apb.penable && tube_apb.pwrite) begin
            if (tube_apb.paddr[2]) begin
                dot_model <= tube_apb.pwdata[5:0];
            end else begin
                digit_model <= tube_apb.pwdata[23:0];
            end
        end
    end

    always_comb begin
        idx = 0;
        for (int i = 0; i < `E902_TUBE_DIGITS; i++) begin
            if (!dig[i]) begin
                idx = i;
            end
        end
        seg_expect = {HEX_SEG[digit_model[4*idx +: 4]], dot_model[idx]};
    end

    // ------------------------------------------------------------------------
    // properties
    // ------------------------------------------------------------------------
    reset_state: assert property (@(posedge clk) $rose(rst_n) |->
        ahb_rsp.hready && !key_int && row == 4'b1110 && dig == 6'b111110)
        else begin fail_count++; $error("state after reset is wrong"); end

    hresp_always_okay: assert property (@(posedge clk) disable iff (!rst_n)
        ahb_rsp.hresp == hresp_okay)
        else begin fail_count++; $error("hresp is not OKAY"); end

    row_one_low: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~row))
        else begin fail_count++; $error("row is not one-hot low"); end

    seg_pattern: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~dig) |-> seg == seg_expect)
        else begin fail_count++; $error("seg does not match the scanned digit"); end

    ram_zero_wait: assert property (@(posedge clk) disable iff (!rst_n)
        accept && region == `E902_REGION_RAM |=> ahb_rsp.hready)
        else begin fail_count++; $error("RAM data phase has a wait state"); end

    unmapped_zero: assert property (@(posedge clk) disable iff (!rst_n)
        accept && region != `E902_REGION_RAM && region != `E902_REGION_APB
        |=> ahb_rsp.hready && ahb_rsp.hrdata == '0)
        else begin fail_count++; $error("unmapped transfer waited or returned data"); end

    // bridge write is setup and access, a read adds the data register cycle
    apb_write_wait: assert property (@(posedge clk) disable iff (!rst_n)
        accept && region == `E902_REGION_APB && ahb_req.hwrite
        |=> !ahb_rsp.hready [*2] ##1 ahb_rsp.hready)
        else begin fail_count++; $error("bridge write wait states are not two"); end

    apb_read_wait: assert property (@(posedge clk) disable iff (!rst_n)
        accept && region == `E902_REGION_APB && !ahb_req.hwrite
        |=> !ahb_rsp.hready [*3] ##1 ahb_rsp.hready)
        else begin fail_count++; $error("bridge read wait states are not three"); end

endmodule

bind e902_soc e902_soc_checker i_e902_soc_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .ahb_req  (ahb_req),
    .ahb_rsp  (ahb_rsp),
    .tube_apb (tube_apb),
    .row      (row),
    .dig      (dig),
    .seg      (seg),
    .key_int  (key_int)
);

/* tb/e902_soc_tb.sv */
`timescale 1ns/1ps

`include "e902_soc_defs.svh"

module e902_soc_tb import ahb_pkg::*, apb_pkg::*; ();

    localparam int RAM_N       = 24;
    localparam int KEY_N       = 3;
    localparam int XFER_CYCLES = 8;
    localparam int KEY_SCAN    = 4 * `E902_KEY_SCAN_DIV;
    localparam int TUBE_SCAN   = `E902_TUBE_DIGITS * `E902_TUBE_SCAN_DIV;
    localparam int TEST_CYCLES = 10 + (3 * RAM_N + 7) * XFER_CYCLES + 2 * TUBE_SCAN
                                 + KEY_N * (2 * KEY_SCAN + 2 * XFER_CYCLES + 12);
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    localparam logic [31:0] KEY_ADDR      = 32'h8000_1000;
    localparam logic [31:0] TUBE_DIG_ADDR = 32'h8000_2000;
    localparam logic [31:0] TUBE_DOT_ADDR = 32'h8000_2004;
    localparam ahb_req_t    IDLE_REQ      = '{haddr: '0, htrans: htrans_idle,
                                              hsize: hsize_word, hwrite: 1'b0};

    logic        clk;
    logic        rst_n;
    ahb_req_t    ahb_req;
    logic [31:0] ahb_hwdata;
    ahb_rsp_t    ahb_rsp;
    logic [3:0]  col_in;
    logic [3:0]  row;
    logic [5:0]  dig;
    seg_t        seg;
    logic        key_int;

    logic [15:0] lfsr_state = 16'd3;
    int          errors     = 0;
    int          cycles     = 0;
    logic        pressed;
    key_code_t   press_key;
    logic [31:0] ram_model [int];
    logic [31:0] ram_addr [$];

    e902_soc i_e902_soc (
        .clk        (clk),
        .rst_n      (rst_n),
        .ahb_req    (ahb_req),
        .ahb_hwdata (ahb_hwdata),
        .ahb_rsp    (ahb_rsp),
        .col_in     (col_in),
        .row        (row),
        .dig        (dig),
        .seg        (seg),
        .key_int    (key_int)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // keypad, a pressed key pulls its column low while its row is driven
    always_comb begin
        col_in = 4'hf;
        if (pressed && !row[press_key[3:2]]) begin
            col_in[press_key[1:0]] = 1'b0;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            v          = {v[30:0], lfsr_state[15]};
            lfsr_state = {lfsr_state[14:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // single NONSEQ transfer, starts and ends just after a rising edge
    // ------------------------------------------------------------------------
    task automatic run_transfer(input logic [31:0] addr, input hsize_t size,
                                input logic write, input logic [31:0] wdata,
                                output logic [31:0] rdata, output int waits);
        logic ready;
        ahb_req <= '{haddr: addr, htrans: htrans_nonseq, hsize: size, hwrite: write};
        do begin
            @(negedge clk);
            ready = ahb_rsp.hready;
            @(posedge clk);
        end while (!ready);
        ahb_req    <= IDLE_REQ;
        ahb_hwdata <= write ? wdata : '0;
        waits = 0;
        @(negedge clk);
        while (!ahb_rsp.hready) begin
            waits++;
            @(negedge clk);
        end
        rdata = ahb_rsp.hrdata;
        @(posedge clk);
    endtask

    task automatic write_access(input string name, input logic [31:0] addr,
                                input hsize_t size, input logic [31:0] data,
                                input int exp_waits);
        logic [31:0] unused;
        int          waits;
        run_transfer(addr, size, 1'b1, data, unused, waits);
        check_value({name, " wait states"}, exp_waits, waits);
    endtask

    task automatic read_access(input string name, input logic [31:0] addr,
                               input int exp_waits, output logic [31:0] data);
        int waits;
        run_transfer(addr, hsize_word, 1'b0, '0, data, waits);
        check_value({name, " wait states"}, exp_waits, waits);
    endtask

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the tests did not complete within %0d cycles", cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  off;
        hsize_t      size;
        int          lanes;
        logic [23:0] digits;
        logic [5:0]  dots;
        key_code_t   key;
        int          waited;
        int          total;

        rst_n      = 1'b0;
        ahb_req    = IDLE_REQ;
        ahb_hwdata = '0;
        pressed    = 1'b0;
        press_key  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // --------------------------------------------------------------------
        // RAM, full word then a byte or half on top
        // --------------------------------------------------------------------
        for (int n = 0; n < RAM_N; n++) begin
            addr = {`E902_REGION_RAM, 14'd0, 14'(rand_bits(14)), 2'b00};
            data = rand_bits(32);
            write_access("ram word write", addr, hsize_word, data, 0);
            ram_model[int'(addr[15:2])] = data;
            ram_addr.push_back(addr);
            size = rand_bits(1) ? hsize_half : hsize_byte;
            off  = 2'(rand_bits(2));
            if (size == hsize_half) begin
                off[0] = 1'b0;
            end
            lanes = 1 << int'(size);
            data  = rand_bits(32);
            write_access("ram lane write", addr | {30'd0, off}, size, data, 0);
            for (int b = 0; b < 4; b++) begin
                if (b >= off && b < off + lanes) begin
                    ram_model[int'(addr[15:2])][8*b +: 8] = data[8*b +: 8];
                end
            end
        end

        // unmapped regions, also keeps the last write apart from the reads
        addr = rand_bits(30);
        read_access("unmapped read 00", addr, 0, rdata);
        check_value("unmapped read 00", 32'h0, rdata);
        addr = rand_bits(30);
        addr[31:30] = 2'b11;
        write_access("unmapped write 11", addr, hsize_word, rand_bits(32), 0);
        read_access("unmapped read 11", addr, 0, rdata);
        check_value("unmapped read 11", 32'h0, rdata);

        foreach (ram_addr[i]) begin
            read_access("ram read", ram_addr[i], 0, rdata);
            check_value("ram read", ram_model[int'(ram_addr[i][15:2])], rdata);
        end

        // --------------------------------------------------------------------
        // tube registers, then two full scans for the seg check
        // --------------------------------------------------------------------
        digits = 24'(rand_bits(24));
        dots   = 6'(rand_bits(6));
        write_access("tube digit write", TUBE_DIG_ADDR, hsize_word, {8'd0, digits}, 2);
        write_access("tube dot write", TUBE_DOT_ADDR, hsize_word, {26'd0, dots}, 2);
        read_access("tube digit read", TUBE_DIG_ADDR, 3, rdata);
        check_value("tube digit read", {8'd0, digits}, rdata);
        read_access("tube dot read", TUBE_DOT_ADDR, 3, rdata);
        check_value("tube dot read", {26'd0, dots}, rdata);
        repeat (2 * TUBE_SCAN) @(posedge clk);

        // --------------------------------------------------------------------
        // keyboard
        // --------------------------------------------------------------------
        for (int k = 0; k < KEY_N; k++) begin
            key       = key_code_t'(rand_bits(4));
            pressed   <= 1'b1;
            press_key <= key;
            waited = 0;
            @(negedge clk);
            while (!key_int && waited < KEY_SCAN + 4) begin
                waited++;
                @(negedge clk);
            end
            assert (key_int) else begin
                errors++;
                $display("key %0d did not raise key_int within one full scan", key);
            end
            @(posedge clk);
            read_access("key status read", KEY_ADDR, 3, rdata);
            check_value("key status read", {27'd0, 1'b1, key}, rdata);
            @(negedge clk);
            check_value("key_int after read", 32'd0, {31'd0, key_int});
            @(posedge clk);
            read_access("key status reread", KEY_ADDR, 3, rdata);
            check_value("key valid after read", 32'd0, {31'd0, rdata[4]});
            pressed <= 1'b0;
            // release is seen once the key's row comes round again
            repeat (KEY_SCAN + 4) @(posedge clk);
        end

        repeat (4) @(posedge clk);
        total = errors + i_e902_soc.i_e902_soc_checker.fail_count;
        $display("check errors: %0d, assertion failures: %0d", errors,
                 i_e902_soc.i_e902_soc_checker.fail_count);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
